// File: design/mq_fifo_pkg.sv
// Queue sizes, APB address map and the APB address union
`default_nettype none

package mq_fifo_pkg;

    localparam int NUM_QUEUES = 4;
    localparam int QUEUE_AW   = 2;
    localparam int DEPTH_AW   = 3;  // 8 entries per queue
    localparam int PTR_W      = DEPTH_AW + 1;  // Extra wrap bit
    localparam int DATA_W     = 32;
    localparam int APB_AW     = 5;
    localparam int REG_AW     = 2;
    localparam int BYTE_AW    = 2;

    localparam logic SPACE_QUEUE = 1'b0;
    localparam logic SPACE_REG   = 1'b1;
    localparam logic [REG_AW-1:0] STATUS_REG = '0;

    typedef struct packed {
        logic                space;
        logic [QUEUE_AW-1:0] queue;
        logic [BYTE_AW-1:0]  offset;
    } apb_queue_addr_t;

    typedef struct packed {
        logic                space;
        logic [REG_AW-1:0]   index;
        logic [BYTE_AW-1:0]  offset;
    } apb_reg_addr_t;

    // Same APB address seen as a queue slot or as a register
    typedef union packed {
        apb_queue_addr_t q;
        apb_reg_addr_t   r;
    } apb_addr_u;

endpackage

`default_nettype wire

// File: design/mq_fifo_if.sv
// Write-port and read-port interfaces of the multi-queue buffer
`timescale 1ns/1ps
`default_nettype none

interface mq_wr_if
    import mq_fifo_pkg::*;
();
    logic                  push;
    logic [QUEUE_AW-1:0]   wq;  // Target queue
    logic [DATA_W-1:0]     wdata;
    logic [NUM_QUEUES-1:0] full;

    modport producer (output push, output wq, output wdata, input full);
    modport buffer (input push, input wq, input wdata, output full);

endinterface

interface mq_rd_if
    import mq_fifo_pkg::*;
();
    logic                  pop;
    logic [QUEUE_AW-1:0]   rq;  // Source queue
    logic [DATA_W-1:0]     rd_data;
    logic [NUM_QUEUES-1:0] empty;

    modport consumer (output pop, output rq, input rd_data, input empty);
    modport buffer (input pop, input rq, output rd_data, output empty);

endinterface

`default_nettype wire

// File: design/gray_counter.sv
// Enabled binary counter with a registered Gray copy
`timescale 1ns/1ps
`default_nettype none

module gray_counter
    import mq_fifo_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cke,
    output logic [PTR_W-1:0] q_bin,
    output logic [PTR_W-1:0] q_gray
);

    logic [PTR_W-1:0] bin_next;

    assign bin_next = q_bin + PTR_W'(1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_bin  <= '0;
            q_gray <= '0;
        end else if (cke) begin
            q_bin  <= bin_next;
            q_gray <= bin_next ^ (bin_next >> 1);  // Tracks q_bin exactly
        end
    end

endmodule

`default_nettype wire

// File: design/mq_ptr_cmp.sv
// Gray pointer synchronizers and full/empty flags of one queue
`timescale 1ns/1ps
`default_nettype none

module mq_ptr_cmp
    import mq_fifo_pkg::*;
(
    input  logic             wclk,
    input  logic             rclk,
    input  logic             rst_n,
    input  logic [PTR_W-1:0] wptr_gray,
    input  logic [PTR_W-1:0] rptr_gray,
    output logic             full,
    output logic             empty
);

    logic [PTR_W-1:0] rptr_s1;
    logic [PTR_W-1:0] rptr_s2;
    logic [PTR_W-1:0] wptr_s1;
    logic [PTR_W-1:0] wptr_s2;

    // Read pointer into the write domain
    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            rptr_s1 <= '0;
            rptr_s2 <= '0;
        end else begin
            rptr_s1 <= rptr_gray;
            rptr_s2 <= rptr_s1;
        end
    end

    // Write pointer into the read domain
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            wptr_s1 <= '0;
            wptr_s2 <= '0;
        end else begin
            wptr_s1 <= wptr_gray;
            wptr_s2 <= wptr_s1;
        end
    end

    // One lap ahead in Gray code flips the two top bits
    assign full = wptr_gray == {~rptr_s2[PTR_W-1:PTR_W-2], rptr_s2[PTR_W-3:0]};

    assign empty = rptr_gray == wptr_s2;

endmodule

`default_nettype wire

// File: design/mq_dpram.sv
// Dual-clock RAM shared by all queues, registered read port
`timescale 1ns/1ps
`default_nettype none

module mq_dpram
    import mq_fifo_pkg::*;
(
    input  logic                         clk_a,
    input  logic                         we_a,
    input  logic [QUEUE_AW+DEPTH_AW-1:0] adr_a,
    input  logic [DATA_W-1:0]            d_a,
    input  logic                         clk_b,
    input  logic [QUEUE_AW+DEPTH_AW-1:0] adr_b,
    output logic [DATA_W-1:0]            q_b
);

    logic [DATA_W-1:0] mem [NUM_QUEUES * (1 << DEPTH_AW)];

    always_ff @(posedge clk_a) begin
        if (we_a) begin
            mem[adr_a] <= d_a;
        end
    end

    always_ff @(posedge clk_b) begin
        q_b <= mem[adr_b];  // Valid one clk_b later
    end

endmodule

`default_nettype wire

// File: design/mq_fifo_buffer.sv
// Per-queue pointers, address muxing and the shared RAM of the multi-queue FIFO
`timescale 1ns/1ps
`default_nettype none

module mq_fifo_buffer
    import mq_fifo_pkg::*;
(
    input  logic      clk1,
    input  logic      clk2,
    input  logic      rst_n,
    mq_wr_if.buffer   wr,
    mq_rd_if.buffer   rd
);

    logic [PTR_W-1:0]      wptr_bin  [NUM_QUEUES];
    logic [PTR_W-1:0]      wptr_gray [NUM_QUEUES];
    logic [PTR_W-1:0]      rptr_bin  [NUM_QUEUES];
    logic [PTR_W-1:0]      rptr_gray [NUM_QUEUES];
    logic [NUM_QUEUES-1:0] wsel;
    logic [NUM_QUEUES-1:0] rsel;
    logic [DEPTH_AW-1:0]   wadr;
    logic [DEPTH_AW-1:0]   radr;

    for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_queue
        assign wsel[i] = wr.wq == QUEUE_AW'(i);  // One-hot queue decode
        assign rsel[i] = rd.rq == QUEUE_AW'(i);

        gray_counter u_wcnt (
            .clk    (clk1),
            .rst_n  (rst_n),
            .cke    (wr.push & wsel[i]),
            .q_bin  (wptr_bin[i]),
            .q_gray (wptr_gray[i])
        );

        gray_counter u_rcnt (
            .clk    (clk2),
            .rst_n  (rst_n),
            .cke    (rd.pop & rsel[i]),
            .q_bin  (rptr_bin[i]),
            .q_gray (rptr_gray[i])
        );

        mq_ptr_cmp u_cmp (
            .wclk      (clk1),
            .rclk      (clk2),
            .rst_n     (rst_n),
            .wptr_gray (wptr_gray[i]),
            .rptr_gray (rptr_gray[i]),
            .full      (wr.full[i]),
            .empty     (rd.empty[i])
        );
    end

    // And-or mux of the selected write pointer
    always_comb begin
        wadr = '0;
        for (int j = 0; j < NUM_QUEUES; j++) begin
            wadr = wadr | (wptr_bin[j][DEPTH_AW-1:0] & {DEPTH_AW{wsel[j]}});
        end
    end

    always_comb begin
        radr = '0;
        for (int k = 0; k < NUM_QUEUES; k++) begin
            radr = radr | (rptr_bin[k][DEPTH_AW-1:0] & {DEPTH_AW{rsel[k]}});
        end
    end

    mq_dpram u_dpram (
        .clk_a (clk1),
        .we_a  (wr.push),
        .adr_a ({wr.wq, wadr}),  // Queue number selects the slice
        .d_a   (wr.wdata),
        .clk_b (clk2),
        .adr_b ({rd.rq, radr}),
        .q_b   (rd.rd_data)
    );

    // Producer must respect the flags computed here
    a_no_push_full: assert property (@(posedge clk1) disable iff (!rst_n)
        wr.push |-> !wr.full[wr.wq]);

    a_no_pop_empty: assert property (@(posedge clk2) disable iff (!rst_n)
        rd.pop |-> !rd.empty[rd.rq]);

endmodule

`default_nettype wire

// File: design/mq_wr_apb.sv
// Producer APB slave on clk1 that pushes words and reports full flags
`timescale 1ns/1ps
`default_nettype none

module mq_wr_apb
    import mq_fifo_pkg::*;
(
    input  logic              clk1,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  apb_addr_u         paddr,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pslverr,
    mq_wr_if.producer         wr
);

    logic access;
    logic q_write;
    logic stat_read;
    logic q_room;

    assign access = psel & penable;

    assign q_write   = pwrite && paddr.q.space == SPACE_QUEUE;
    assign stat_read = !pwrite && paddr.r.space == SPACE_REG
                       && paddr.r.index == STATUS_REG;
    assign q_room    = !wr.full[paddr.q.queue];

    assign wr.wq    = paddr.q.queue;
    assign wr.wdata = pwdata;
    assign wr.push  = access & q_write & q_room;  // One cycle per transfer

    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        if (access) begin
            if (stat_read) begin
                prdata = {{(DATA_W-NUM_QUEUES){1'b0}}, wr.full};
            end else if (!(q_write && q_room)) begin
                pslverr = 1'b1;  // Full queue or bad access
            end
        end
    end

    // Access phase only after a setup phase
    a_apb_setup: assert property (@(posedge clk1) disable iff (!rst_n)
        penable |-> psel && $past(psel));

endmodule

`default_nettype wire

// File: design/mq_rd_apb.sv
// Consumer APB slave on clk2 that pops words and reports empty flags
`timescale 1ns/1ps
`default_nettype none

module mq_rd_apb
    import mq_fifo_pkg::*;
(
    input  logic              clk2,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  apb_addr_u         paddr,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pslverr,
    mq_rd_if.consumer         rd
);

    logic access;
    logic q_read;
    logic stat_read;
    logic q_avail;

    assign access = psel & penable;

    // Address is stable from setup, so the RAM read lands in the access cycle
    assign rd.rq = paddr.q.queue;

    assign q_read    = !pwrite && paddr.q.space == SPACE_QUEUE;
    assign stat_read = !pwrite && paddr.r.space == SPACE_REG
                       && paddr.r.index == STATUS_REG;
    assign q_avail   = !rd.empty[rd.rq];

    assign rd.pop = access & q_read & q_avail;

    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        if (access) begin
            if (q_read && q_avail) begin
                prdata = rd.rd_data;  // Head word
            end else if (stat_read) begin
                prdata = {{(DATA_W-NUM_QUEUES){1'b0}}, rd.empty};
            end else begin
                pslverr = 1'b1;
            end
        end
    end

    // Pop needs the setup cycle before it to fetch the head
    a_pop_after_setup: assert property (@(posedge clk2) disable iff (!rst_n)
        rd.pop |-> psel && penable && $past(psel && !penable));

    // Writes are refused but must still carry defined data
    a_wdata_known: assert property (@(posedge clk2) disable iff (!rst_n)
        psel && pwrite |-> !$isunknown(pwdata));

endmodule

`default_nettype wire

// File: design/mq_fifo_top.sv
// Multi-queue async FIFO top level with write and read APB slaves
`timescale 1ns/1ps
`default_nettype none

module mq_fifo_top
    import mq_fifo_pkg::*;
(
    input  logic              clk1,
    input  logic              clk2,
    input  logic              rst_n,
    input  logic              w_psel,
    input  logic              w_penable,
    input  logic              w_pwrite,
    input  logic [APB_AW-1:0] w_paddr,
    input  logic [DATA_W-1:0] w_pwdata,
    output logic [DATA_W-1:0] w_prdata,
    output logic              w_pslverr,
    input  logic              r_psel,
    input  logic              r_penable,
    input  logic              r_pwrite,
    input  logic [APB_AW-1:0] r_paddr,
    input  logic [DATA_W-1:0] r_pwdata,
    output logic [DATA_W-1:0] r_prdata,
    output logic              r_pslverr
);

    mq_wr_if u_wr_if ();
    mq_rd_if u_rd_if ();

    mq_wr_apb u_wr_apb (
        .clk1    (clk1),
        .rst_n   (rst_n),
        .psel    (w_psel),
        .penable (w_penable),
        .pwrite  (w_pwrite),
        .paddr   (w_paddr),
        .pwdata  (w_pwdata),
        .prdata  (w_prdata),
        .pslverr (w_pslverr),
        .wr      (u_wr_if.producer)
    );

    mq_fifo_buffer u_buffer (
        .clk1  (clk1),
        .clk2  (clk2),
        .rst_n (rst_n),
        .wr    (u_wr_if.buffer),
        .rd    (u_rd_if.buffer)
    );

    mq_rd_apb u_rd_apb (
        .clk2    (clk2),
        .rst_n   (rst_n),
        .psel    (r_psel),
        .penable (r_penable),
        .pwrite  (r_pwrite),
        .paddr   (r_paddr),
        .pwdata  (r_pwdata),
        .prdata  (r_prdata),
        .pslverr (r_pslverr),
        .rd      (u_rd_if.consumer)
    );

endmodule

`default_nettype wire

// File: verif/mq_fifo_tb.sv
// Testbench with clocks, reset, LFSR stimulus, queue models and response assertions
`timescale 1ns/1ps
`default_nettype none

module mq_fifo_tb
    import mq_fifo_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int QUEUE_DEPTH    = 1 << DEPTH_AW;
    localparam int RAND_WRITES    = 20;
    localparam int RAND_READS     = 24;
    localparam logic [DATA_W-1:0] FLAG_MASK = DATA_W'((1 << NUM_QUEUES) - 1);

    logic              clk1 = 1'b0;
    logic              clk2 = 1'b0;
    logic              rst_n;
    logic              w_psel;
    logic              w_penable;
    logic              w_pwrite;
    logic [APB_AW-1:0] w_paddr;
    logic [DATA_W-1:0] w_pwdata;
    logic [DATA_W-1:0] w_prdata;
    logic              w_pslverr;
    logic              r_psel;
    logic              r_penable;
    logic              r_pwrite;
    logic [APB_AW-1:0] r_paddr;
    logic [DATA_W-1:0] r_pwdata;
    logic [DATA_W-1:0] r_prdata;
    logic              r_pslverr;

    // Expected response of the current access phase, per port
    logic [DATA_W-1:0] w_exp_data;
    logic [DATA_W-1:0] w_exp_mask;
    logic              w_exp_err;
    logic [DATA_W-1:0] r_exp_data;
    logic [DATA_W-1:0] r_exp_mask;
    logic              r_exp_err;

    logic [DATA_W-1:0] model_q [NUM_QUEUES][$];
    logic [31:0]       lfsr_state = 32'd96561;
    int                cycle_cnt = 0;

    always #50 clk1 = ~clk1;
    always #65 clk2 = ~clk2;

    mq_fifo_top u_mq_fifo_top (
        .clk1      (clk1),
        .clk2      (clk2),
        .rst_n     (rst_n),
        .w_psel    (w_psel),
        .w_penable (w_penable),
        .w_pwrite  (w_pwrite),
        .w_paddr   (w_paddr),
        .w_pwdata  (w_pwdata),
        .w_prdata  (w_prdata),
        .w_pslverr (w_pslverr),
        .r_psel    (r_psel),
        .r_penable (r_penable),
        .r_pwrite  (r_pwrite),
        .r_paddr   (r_paddr),
        .r_pwdata  (r_pwdata),
        .r_prdata  (r_prdata),
        .r_pslverr (r_pslverr)
    );

    task automatic report_mismatch(input string port);
        $display("Error at %0t ns: %s port response differs from the queue model", $time, port);
        $display("TB FAILED");
        $fatal(1, "Response check failed");
    endtask

    a_w_resp: assert property (@(posedge clk1) disable iff (!rst_n)
        w_psel && w_penable |->
            (((w_prdata ^ w_exp_data) & w_exp_mask) == '0) && w_pslverr == w_exp_err)
        else report_mismatch("Write");

    a_r_resp: assert property (@(posedge clk2) disable iff (!rst_n)
        r_psel && r_penable |->
            (((r_prdata ^ r_exp_data) & r_exp_mask) == '0) && r_pslverr == r_exp_err)
        else report_mismatch("Read");

    always @(posedge clk1) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d clk1 cycles, the tests did not complete", cycle_cnt);
            $display("TB FAILED");
            $fatal(1, "Timeout");
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [APB_AW-1:0] queue_addr(input logic [QUEUE_AW-1:0] q);
        return {1'b0, q, 2'b00};
    endfunction

    function automatic logic [APB_AW-1:0] reg_addr(input logic [REG_AW-1:0] idx);
        return {1'b1, idx, 2'b00};
    endfunction

    function automatic logic [DATA_W-1:0] full_vec();
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < NUM_QUEUES; i++) begin
            v = v | (DATA_W'(model_q[i].size() == QUEUE_DEPTH) << i);
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] empty_vec();
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < NUM_QUEUES; i++) begin
            v = v | (DATA_W'(model_q[i].size() == 0) << i);
        end
        return v;
    endfunction

    task automatic write_access(input logic wr, input logic [APB_AW-1:0] addr,
                                input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] mask, input logic err,
                                output logic [DATA_W-1:0] rsp);
        @(posedge clk1);
        w_psel    <= 1'b1;
        w_penable <= 1'b0;
        w_pwrite  <= wr;
        w_paddr   <= addr;
        w_pwdata  <= data;
        @(posedge clk1);
        w_penable  <= 1'b1;
        w_exp_data <= exp;
        w_exp_mask <= mask;
        w_exp_err  <= err;
        @(negedge clk1);
        rsp = w_prdata;
        @(posedge clk1);
        w_psel    <= 1'b0;
        w_penable <= 1'b0;
    endtask

    task automatic read_access(input logic wr, input logic [APB_AW-1:0] addr,
                               input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] mask, input logic err,
                               output logic [DATA_W-1:0] rsp);
        @(posedge clk2);
        r_psel    <= 1'b1;
        r_penable <= 1'b0;
        r_pwrite  <= wr;
        r_paddr   <= addr;
        r_pwdata  <= data;
        @(posedge clk2);
        r_penable  <= 1'b1;
        r_exp_data <= exp;
        r_exp_mask <= mask;
        r_exp_err  <= err;
        @(negedge clk2);
        rsp = r_prdata;
        @(posedge clk2);
        r_psel    <= 1'b0;
        r_penable <= 1'b0;
    endtask

    task automatic push_word(input logic [QUEUE_AW-1:0] q, input logic [DATA_W-1:0] data);
        logic              err;
        logic [DATA_W-1:0] rsp;
        err = model_q[q].size() == QUEUE_DEPTH;  // Refused when full
        write_access(1'b1, queue_addr(q), data, '0, '1, err, rsp);
        if (!err) begin
            model_q[q].push_back(data);
        end
    endtask

    // Flags of queues the model holds as empty must already be set
    task automatic wait_not_empty(input logic [QUEUE_AW-1:0] q);
        logic [DATA_W-1:0] rsp;
        do begin
            read_access(1'b0, reg_addr(STATUS_REG), '0, empty_vec(), ~FLAG_MASK | empty_vec(),
                        1'b0, rsp);
        end while (rsp[q]);
    endtask

    task automatic wait_not_full(input logic [QUEUE_AW-1:0] q);
        logic [DATA_W-1:0] rsp;
        do begin
            write_access(1'b0, reg_addr(STATUS_REG), '0, full_vec(), ~FLAG_MASK | full_vec(),
                         1'b0, rsp);
        end while (rsp[q]);
    endtask

    task automatic pop_word(input logic [QUEUE_AW-1:0] q);
        logic [DATA_W-1:0] exp;
        logic [DATA_W-1:0] rsp;
        if (model_q[q].size() == 0) begin
            read_access(1'b0, queue_addr(q), '0, '0, '1, 1'b1, rsp);
        end else begin
            wait_not_empty(q);
            exp = model_q[q].pop_front();
            read_access(1'b0, queue_addr(q), '0, exp, '1, 1'b0, rsp);
        end
    endtask

    task automatic check_flags_exact();
        logic [DATA_W-1:0] rsp;
        write_access(1'b0, reg_addr(STATUS_REG), '0, full_vec(), '1, 1'b0, rsp);
        read_access(1'b0, reg_addr(STATUS_REG), '0, empty_vec(), '1, 1'b0, rsp);
    endtask

    initial begin
        logic [31:0]         val;
        logic [31:0]         word;
        logic [DATA_W-1:0]   rsp;
        logic [QUEUE_AW-1:0] q;
        rst_n      <= 1'b0;
        w_psel     <= 1'b0;
        w_penable  <= 1'b0;
        w_pwrite   <= 1'b0;
        w_paddr    <= '0;
        w_pwdata   <= '0;
        r_psel     <= 1'b0;
        r_penable  <= 1'b0;
        r_pwrite   <= 1'b0;
        r_paddr    <= '0;
        r_pwdata   <= '0;
        w_exp_data <= '0;
        w_exp_mask <= '0;
        w_exp_err  <= 1'b0;
        r_exp_data <= '0;
        r_exp_mask <= '0;
        r_exp_err  <= 1'b0;
        repeat (3) @(posedge clk1);
        #20;
        rst_n <= 1'b1;  // Clear of both clock edges
        check_flags_exact();
        for (int i = 0; i < RAND_WRITES; i++) begin
            take_bits(QUEUE_AW, val);
            take_bits(DATA_W, word);
            push_word(val[QUEUE_AW-1:0], word);
        end
        // Bad accesses on both ports leave every queue alone
        write_access(1'b0, reg_addr(2'd2), '0, '0, '1, 1'b1, rsp);
        write_access(1'b1, reg_addr(STATUS_REG), 32'hdead_beef, '0, '1, 1'b1, rsp);
        write_access(1'b0, queue_addr(2'd1), '0, '0, '1, 1'b1, rsp);
        read_access(1'b1, queue_addr(2'd2), 32'h1234_5678, '0, '1, 1'b1, rsp);
        read_access(1'b0, reg_addr(2'd3), '0, '0, '1, 1'b1, rsp);
        read_access(1'b1, reg_addr(STATUS_REG), 32'h0, '0, '1, 1'b1, rsp);
        for (int i = 0; i < RAND_READS; i++) begin
            take_bits(QUEUE_AW, val);
            pop_word(val[QUEUE_AW-1:0]);
        end
        for (int i = 0; i < NUM_QUEUES; i++) begin
            q = QUEUE_AW'(i);
            while (model_q[q].size() > 0) begin
                pop_word(q);
            end
            wait_not_full(q);
        end
        take_bits(QUEUE_AW, val);
        q = val[QUEUE_AW-1:0];
        for (int i = 0; i <= QUEUE_DEPTH; i++) begin
            take_bits(DATA_W, word);
            push_word(q, word);  // Ninth one is refused
        end
        check_flags_exact();
        for (int i = 0; i <= QUEUE_DEPTH; i++) begin
            pop_word(q);
        end
        wait_not_full(q);
        check_flags_exact();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/mq_fifo_pkg.sv
design/mq_fifo_if.sv
design/gray_counter.sv
design/mq_ptr_cmp.sv
design/mq_dpram.sv
design/mq_fifo_buffer.sv
design/mq_wr_apb.sv
design/mq_rd_apb.sv
design/mq_fifo_top.sv
verif/mq_fifo_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the multi-queue FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module mq_fifo_tb || exit 1

sim_out="$(./obj_dir/Vmq_fifo_tb 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -q "^TB PASSED$" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
